// File: Makefile
# build and run the SPI master testbench with Verilator

TOP := spi_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o V$(TOP)

# the run fails on a nonzero exit status or when the log reports failure
run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Regression failed" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir sim.log

// File: dv/spi_assert.sv
// ~~~~~~~~~~~~~~~~~~~~
// assumes sclk idles low and eight active-low selects, as in spi_master_top
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_assert (
    input wire logic                              clock,
    input wire logic                              reset,
    input wire logic                              ready,
    input wire logic                              sclk,
    input wire logic [7:0]                        sen,
    input wire spi_pkg::spi_state_t               state,
    input wire logic [spi_pkg::spi_divider_w-1:0] divider
);

    import spi_pkg::*;

    localparam int len_w = spi_divider_w + 1;

    // sclk level at the previous clock edge
    logic             sclk_q;
    // an sclk high period has already ended in this transfer
    logic             clocked;
    // cycles spent so far at the level of sclk_q
    logic [len_w-1:0] run_len;
    // number of assertion failures
    int               error_count = 0;

    always_ff @(posedge clock) begin
        sclk_q <= sclk;
        if (reset || (sclk != sclk_q)) begin
            run_len <= len_w'(1);
        end else begin
            run_len <= run_len + len_w'(1);
        end
        // the low time before the first high period is not a half period
        if (reset || (state == wait_trig)) begin
            clocked <= 1'b0;
        end else if (sclk_q && !sclk) begin
            clocked <= 1'b1;
        end
    end

    // no clock and no select while the core is ready
    idle_when_ready: assert property (@(posedge clock) disable iff (reset)
        ready |-> (!sclk && (sen == 8'hff)))
        else begin
            $error("sclk or a select active while ready is high");
            error_count++;
        end

    // each sclk high period lasts divider+1 cycles
    sclk_high_len: assert property (@(posedge clock) disable iff (reset)
        (sclk_q && !sclk) |-> (run_len == len_w'(divider) + len_w'(1)))
        else begin
            $error("sclk high period differs from divider+1 cycles");
            error_count++;
        end

    // low periods between two high periods of one transfer
    sclk_low_len: assert property (@(posedge clock) disable iff (reset)
        (!sclk_q && sclk && clocked) |-> (run_len == len_w'(divider) + len_w'(1)))
        else begin
            $error("sclk low period differs from divider+1 cycles");
            error_count++;
        end

endmodule

`default_nettype wire

// File: dv/spi_slave_model.sv
// ~~~~~~~~~~~~~~~~~~~~
// edge inputs must match the master's config, one transfer is one select low period
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_slave_model (
    input  wire logic        sclk,
    input  wire logic        sel_n,
    input  wire logic        mosi,
    input  wire logic        launch_rise,
    input  wire logic        capture_rise,
    input  wire logic [5:0]  num_bits,
    input  wire logic [31:0] reply,
    output logic             miso,
    output logic [31:0]      mosi_bits,
    output int               bit_count,
    output int               word_count
);

    logic        miso_q  = 1'b0;
    logic [31:0] shift_q = '0;
    int          taken   = 0;
    int          sent    = 0;
    int          words   = 0;
    // previous pin levels for edge detection
    logic        sclk_q  = 1'b0;
    logic        sel_q   = 1'b1;

    assign miso       = miso_q;
    assign mosi_bits  = shift_q;
    assign bit_count  = taken;
    assign word_count = words;

    always @(sclk or sel_n) begin
        logic drive_now;
        drive_now = 1'b0;
        if (sel_q === 1'b1 && sel_n === 1'b0) begin
            // start of a transfer
            shift_q = '0;
            taken   = 0;
            sent    = 0;
            miso_q  = 1'b0;
            // master samples on rising sclk, so the first bit must be out already
            drive_now = capture_rise;
        end else if (sel_q === 1'b0 && sel_n === 1'b1) begin
            words = words + 1;
        end else if (sel_n === 1'b0 && sclk !== sclk_q) begin
            // mosi is stable on the edge opposite to the launch edge
            if (sclk !== launch_rise) begin
                shift_q = {shift_q[30:0], mosi};
                taken   = taken + 1;
            end
            // change miso away from the master's sampling edge
            drive_now = (sclk !== capture_rise);
        end
        // reply goes out msb of the num_bits field first
        if (drive_now && sent < int'(num_bits)) begin
            miso_q = reply[int'(num_bits) - 1 - sent];
            sent   = sent + 1;
        end
        sclk_q = sclk;
        sel_q  = sel_n;
    end

endmodule

`default_nettype wire

// File: dv/spi_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// table driven test of spi_master_top, masks only use the eight select lines
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_tb;

    import spi_pkg::*;

    // one row of the stimulus table
    typedef struct {
        string       name;
        logic [15:0] divider;
        logic [5:0]  bits;
        logic        out_edge;
        logic        in_edge;
        logic [7:0]  mask;
        logic [31:0] tx;
        logic [31:0] reply;
        logic        overrun;
    } test_row_t;

    logic        clock = 1'b0;
    logic        reset;
    logic        set_stb;
    logic [7:0]  set_addr;
    logic [31:0] set_data;
    logic [31:0] readback;
    logic        ready;
    logic [7:0]  sen;
    logic        sclk;
    logic        mosi;
    logic        miso;

    // slave setup for the current row
    logic        slave_launch;
    logic        slave_capture;
    logic [5:0]  slave_bits;
    logic [31:0] slave_reply;
    logic [31:0] slave_mosi_bits;
    int          slave_bit_count;
    int          slave_words;

    test_row_t   rows[$];
    logic [31:0] lfsr = 32'h98ac_72bc;
    string       current_test;
    int          row_errors;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;
    int          cycle_limit;

    spi_master_top uut (
        .clock, .reset, .set_stb, .set_addr, .set_data,
        .readback, .ready, .sen, .sclk, .mosi, .miso
    );

    // device answers whenever any select is low
    spi_slave_model slave (
        .sclk, .sel_n (&sen), .mosi, .launch_rise (slave_launch),
        .capture_rise (slave_capture), .num_bits (slave_bits), .reply (slave_reply),
        .miso, .mosi_bits (slave_mosi_bits), .bit_count (slave_bit_count),
        .word_count (slave_words)
    );

    bind spi_master_top spi_assert pin_checks (
        .clock, .reset, .ready, .sclk, .sen,
        .state   (spi_core.state),
        .divider (spi_core.divider)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the core never became ready", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    // Galois form of x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one step per bit taken
    task automatic random_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [31:0] low_mask(input logic [5:0] n);
        if (n >= 6'd32) begin
            return 32'hffff_ffff;
        end
        return (32'd1 << n) - 32'd1;
    endfunction

    task automatic add_row(input string name, input logic [15:0] div, input logic [5:0] bits,
                           input logic oe, input logic ie, input logic [7:0] mask,
                           input logic [31:0] tx, input logic [31:0] reply, input logic ovr);
        test_row_t r;
        r.name     = name;
        r.divider  = div;
        r.bits     = bits;
        r.out_edge = oe;
        r.in_edge  = ie;
        r.mask     = mask;
        r.tx       = tx;
        r.reply    = reply;
        r.overrun  = ovr;
        rows.push_back(r);
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clock);
        #1;
        set_stb  = 1'b1;
        set_addr = addr;
        set_data = data;
        @(posedge clock);
        #1;
        set_stb  = 1'b0;
    endtask

    // outputs are sampled on the falling clock edge
    task automatic wait_ready_level(input logic level);
        @(negedge clock);
        while (ready !== level) @(negedge clock);
    endtask

    // collect select lines seen low until ready rises again
    task automatic wait_transfer_end(output logic [7:0] low_seen);
        low_seen = 8'h00;
        @(negedge clock);
        while (ready !== 1'b1) begin
            low_seen = low_seen | ~sen;
            @(negedge clock);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch %s %s: expected %h, actual %h",
                     current_test, what, expected, actual);
            row_errors++;
        end
    endtask

    task automatic report_test();
        if (row_errors == 0) begin
            pass_count++;
            $display("test %s: ok", current_test);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", current_test, row_errors);
        end
    endtask

    task automatic run_row(input test_row_t r);
        logic [31:0] keep;
        logic [7:0]  low_seen;
        int          words_before;
        keep          = low_mask(r.bits);
        current_test  = r.name;
        row_errors    = 0;
        slave_launch  = r.out_edge;
        slave_capture = r.in_edge;
        slave_bits    = r.bits;
        slave_reply   = r.reply;
        wait_ready_level(1'b1);
        bus_write(spi_addr_divider, {16'h0000, r.divider});
        bus_write(spi_addr_config, {r.out_edge, r.in_edge, r.bits, 16'h0000, r.mask});
        words_before = slave_words;
        bus_write(spi_addr_data, r.tx);
        wait_ready_level(1'b0);
        // a second trigger while busy must be lost
        if (r.overrun) bus_write(spi_addr_data, ~r.tx);
        wait_transfer_end(low_seen);
        if (r.overrun) begin
            repeat (2 * (int'(r.divider) + 1) + 4) @(negedge clock);
            check_value("ready after overrun", 32'd1, {31'd0, ready});
        end
        // mosi carries the top bits of the word, msb first
        check_value("mosi data", r.tx >> (32 - int'(r.bits)), slave_mosi_bits);
        check_value("mosi bit count", 32'(r.bits), 32'(slave_bit_count));
        check_value("miso data", r.reply & keep, readback & keep);
        check_value("selects low", {24'h0, r.mask}, {24'h0, low_seen});
        check_value("selects idle", 32'h0000_00ff, {24'h0, sen});
        check_value("words seen", 32'd1, 32'(slave_words - words_before));
        report_test();
    endtask

    initial begin
        logic [31:0] w_tx;
        logic [31:0] w_rx;
        reset    = 1'b1;
        set_stb  = 1'b0;
        set_addr = 8'h00;
        set_data = 32'h0;
        slave_launch  = 1'b0;
        slave_capture = 1'b1;
        slave_bits    = 6'd8;
        slave_reply   = 32'h0;

        // name div bits out in mask tx reply overrun
        add_row("bits8_mode0", 16'd1, 6'd8, 1'b0, 1'b1, 8'h01, 32'hA5C3_0000, 32'h3C, 1'b0);
        add_row("bits1", 16'd2, 6'd1, 1'b0, 1'b1, 8'h02, 32'h8000_0000, 32'h1, 1'b0);
        add_row("bits32", 16'd3, 6'd32, 1'b0, 1'b1, 8'h80, 32'hDEAD_BEEF, 32'h1234_5678, 1'b0);
        add_row("edges_00", 16'd2, 6'd12, 1'b0, 1'b0, 8'h04, 32'h9F30_0000, 32'hA5B, 1'b0);
        add_row("edges_01", 16'd2, 6'd12, 1'b0, 1'b1, 8'h08, 32'h6C90_0000, 32'h5E1, 1'b0);
        add_row("edges_10", 16'd2, 6'd12, 1'b1, 1'b0, 8'h10, 32'hB170_0000, 32'hC3D, 1'b0);
        add_row("edges_11", 16'd2, 6'd12, 1'b1, 1'b1, 8'h20, 32'h4E20_0000, 32'h92F, 1'b0);
        add_row("div0", 16'd0, 6'd16, 1'b1, 1'b0, 8'h41, 32'h55AA_0000, 32'hC3E1, 1'b0);
        add_row("div3", 16'd3, 6'd8, 1'b1, 1'b1, 8'h03, 32'h7100_0000, 32'h96, 1'b0);
        random_word(w_tx);
        random_word(w_rx);
        add_row("random_a", 16'd1, 6'd24, 1'b1, 1'b1, 8'h0c, w_tx, w_rx, 1'b0);
        random_word(w_tx);
        random_word(w_rx);
        add_row("random_b", 16'd0, 6'd5, 1'b0, 1'b0, 8'h30, w_tx, w_rx, 1'b0);
        random_word(w_tx);
        random_word(w_rx);
        add_row("random_c", 16'd2, 6'd32, 1'b1, 1'b0, 8'hff, w_tx, w_rx, 1'b0);
        add_row("overrun", 16'd1, 6'd10, 1'b0, 1'b1, 8'h01, 32'hF0F0_0000, 32'h2AB, 1'b1);

        // pre_idle, 2 halves per bit, post_idle and idle_sen plus bus overhead
        cycle_limit = 200;
        foreach (rows[i]) begin
            cycle_limit += (2 * int'(rows[i].bits) + 4) * (int'(rows[i].divider) + 1) + 20;
        end

        // reset held for two cycles, ready comes up one cycle later
        current_test = "reset_state";
        row_errors   = 0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        repeat (2) @(negedge clock);
        check_value("ready", 32'd1, {31'd0, ready});
        check_value("sclk idle", 32'd0, {31'd0, sclk});
        check_value("selects idle", 32'h0000_00ff, {24'h0, sen});
        report_test();

        foreach (rows[i]) begin
            run_row(rows[i]);
        end

        // failures of the bound pin assertions over the whole run
        current_test = "pin_assertions";
        row_errors   = 0;
        check_value("assertion failures", 32'd0, 32'(uut.pin_checks.error_count));
        report_test();

        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
rtl/spi_pkg.sv
rtl/spi_phase_if.sv
rtl/setting_reg.sv
rtl/spi_sclk_timer.sv
rtl/spi_shift_engine.sv
rtl/simple_spi_core.sv
rtl/spi_master_top.sv
dv/spi_slave_model.sv
dv/spi_assert.sv
dv/spi_tb.sv

// File: rtl/setting_reg.sv
// ~~~~~~~~~~~~~~~~~~~~
// payload takes the low bits of set_data, changed follows the write by one cycle
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module setting_reg #(
    parameter logic [7:0] my_addr = 8'd0,
    parameter type payload_t = logic [spi_pkg::spi_data_w-1:0]
) (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire logic                          set_stb,
    input  wire logic [7:0]                    set_addr,
    input  wire logic [spi_pkg::spi_data_w-1:0] set_data,
    output payload_t                           out,
    output logic                               changed
);

    // this register is the target of the current bus cycle
    logic hit;
    assign hit = set_stb && (set_addr == my_addr);

    always_ff @(posedge clock) begin
        if (reset) begin
            out     <= '0;
            changed <= 1'b0;
        end else begin
            // pulse for exactly one cycle per write
            changed <= hit;
            if (hit) begin
                out <= payload_t'(set_data[$bits(payload_t)-1:0]);
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/simple_spi_core.sv
// ~~~~~~~~~~~~~~~~~~~~
// one transfer at a time, data writes while ready is low are dropped, num_sen is at most 24
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module simple_spi_core #(
    parameter logic [7:0]  base     = 8'd0,
    parameter int          num_sen  = 8,
    parameter logic        clk_idle = 1'b0,
    parameter logic [23:0] sen_idle = 24'hff_ffff
) (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire logic                          set_stb,
    input  wire logic [7:0]                    set_addr,
    input  wire logic [spi_pkg::spi_data_w-1:0] set_data,
    output logic [spi_pkg::spi_data_w-1:0]     readback,
    output logic                               ready,
    output logic [num_sen-1:0]                 sen,
    output logic                               sclk,
    output logic                               mosi,
    input  wire logic                          miso
);

    import spi_pkg::*;

    logic [spi_divider_w-1:0] divider;
    spi_config_t              cfg;
    logic [spi_data_w-1:0]    tx_word;
    logic                     trigger;
    logic                     tick;
    spi_state_t               state;
    logic [23:0]              sen_full;

    spi_phase_if phase ();

    // base+0 sclk divider
    setting_reg #(
        .my_addr   (8'(base + spi_addr_divider)),
        .payload_t (logic [spi_divider_w-1:0])
    ) divider_reg (
        .clock, .reset, .set_stb, .set_addr, .set_data,
        .out     (divider),
        .changed ()
    );

    // base+1 selects, bit count and edges
    setting_reg #(
        .my_addr   (8'(base + spi_addr_config)),
        .payload_t (spi_config_t)
    ) config_reg (
        .clock, .reset, .set_stb, .set_addr, .set_data,
        .out     (cfg),
        .changed ()
    );

    // base+2 transmit word, the write itself is the trigger
    setting_reg #(
        .my_addr   (8'(base + spi_addr_data)),
        .payload_t (logic [spi_data_w-1:0])
    ) data_reg (
        .clock, .reset, .set_stb, .set_addr, .set_data,
        .out     (tx_word),
        .changed (trigger)
    );

    spi_sclk_timer timer (
        .clock, .reset,
        .run     (state != wait_trig),
        .divider (divider),
        .tick    (tick)
    );

    spi_shift_engine #(.clk_idle(clk_idle)) engine (
        .clock, .phase, .cfg, .tx_word, .miso, .mosi,
        .rx_word (readback)
    );

    // phase events toward the shift engine
    assign phase.load       = (state == wait_trig);
    assign phase.clear      = (state == wait_trig);
    assign phase.first_half = (state == clk_reg);
    assign phase.half_done  = tick && ((state == clk_reg) || (state == clk_inv));

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= wait_trig;
            ready <= 1'b0;
            sclk  <= clk_idle;
        end else begin
            case (state)
                wait_trig: begin
                    // ready drops on the same edge the transfer starts
                    if (trigger) state <= pre_idle;
                    ready <= ~trigger;
                    sclk  <= clk_idle;
                end
                pre_idle: begin
                    if (tick) state <= clk_reg;
                    sclk <= clk_idle;
                end
                clk_reg: begin
                    // leave idle level at the end of this half
                    if (tick) begin
                        state <= clk_inv;
                        sclk  <= ~clk_idle;
                    end
                end
                clk_inv: begin
                    if (tick) begin
                        state <= phase.last_bit ? post_idle : clk_reg;
                        sclk  <= clk_idle;
                    end
                end
                post_idle: begin
                    if (tick) state <= idle_sen;
                    sclk <= clk_idle;
                end
                idle_sen: begin
                    // selects already back at idle here
                    if (tick) state <= wait_trig;
                    sclk <= clk_idle;
                end
                default: state <= wait_trig;
            endcase
        end
    end

    // selected lines flip away from idle from pre_idle through post_idle
    assign sen_full = ((state == wait_trig) || (state == idle_sen)) ?
                      sen_idle : (sen_idle ^ cfg.slave_select);

    always_ff @(posedge clock) begin
        if (reset) begin
            sen <= sen_idle[num_sen-1:0];
        end else begin
            sen <= sen_full[num_sen-1:0];
        end
    end

endmodule

`default_nettype wire

// File: rtl/spi_master_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// eight active-low selects, sclk idles low, registers at base 0
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_master_top (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire logic                          set_stb,
    input  wire logic [7:0]                    set_addr,
    input  wire logic [spi_pkg::spi_data_w-1:0] set_data,
    output logic [spi_pkg::spi_data_w-1:0]     readback,
    output logic                               ready,
    output logic [7:0]                         sen,
    output logic                               sclk,
    output logic                               mosi,
    input  wire logic                          miso
);

    // mode 0 style idle levels, the edges come from the config register
    simple_spi_core #(
        .base     (8'd0),
        .num_sen  (8),
        .clk_idle (1'b0),
        .sen_idle (24'hff_ffff)
    ) spi_core (
        .clock, .reset,
        .set_stb, .set_addr, .set_data,
        .readback, .ready,
        .sen, .sclk, .mosi, .miso
    );

endmodule

`default_nettype wire

// File: rtl/spi_phase_if.sv
// ~~~~~~~~~~~~~~~~~~~~
// half-period events from the sequencer, valid for one clock cycle each
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface spi_phase_if;

    // copy the transmit word into the shift register
    logic load;
    // last cycle of a clock half period
    logic half_done;
    // high while in the clk_reg half, low in clk_inv
    logic first_half;
    // restart the bit count
    logic clear;
    // bit count has reached num_bits
    logic last_bit;

    // transfer FSM side
    modport sequencer (
        output load,
        output half_done,
        output first_half,
        output clear,
        input  last_bit
    );

    // shift register side
    modport engine (
        input  load,
        input  half_done,
        input  first_half,
        input  clear,
        output last_bit
    );

endinterface

`default_nettype wire

// File: rtl/spi_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// register map and shared types of the SPI master, offsets are relative to the core base
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package spi_pkg;

    // register offsets from the base address
    localparam logic [7:0] spi_addr_divider = 8'd0;
    localparam logic [7:0] spi_addr_config  = 8'd1;
    localparam logic [7:0] spi_addr_data    = 8'd2;

    // field widths
    localparam int spi_divider_w = 16;
    localparam int spi_data_w    = 32;
    localparam int spi_bitcnt_w  = 7;

    // configuration word as written to base+1
    // num_bits runs 1 to 32, bit 0 of slave_select is slave 0
    typedef struct packed {
        logic        dataout_edge;
        logic        datain_edge;
        logic [5:0]  num_bits;
        logic [23:0] slave_select;
    } spi_config_t;

    // transfer sequencer states
    typedef enum logic [2:0] {
        wait_trig = 3'd0,
        pre_idle  = 3'd1,
        clk_reg   = 3'd2,
        clk_inv   = 3'd3,
        post_idle = 3'd4,
        idle_sen  = 3'd5
    } spi_state_t;

endpackage

`default_nettype wire

// File: rtl/spi_sclk_timer.sv
// ~~~~~~~~~~~~~~~~~~~~
// a half period is divider+1 cycles, the count stays at 0 while run is low
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_sclk_timer (
    input  wire logic                             clock,
    input  wire logic                             reset,
    input  wire logic                             run,
    input  wire logic [spi_pkg::spi_divider_w-1:0] divider,
    output logic                                  tick
);

    logic [spi_pkg::spi_divider_w-1:0] count;

    // top of the count, only meaningful while running
    assign tick = run && (count == divider);

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (!run) begin
            // idle, so the first state after the trigger starts from a clean count
            count <= '0;
        end else if (tick) begin
            // wrap for the next half period
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/spi_shift_engine.sv
// ~~~~~~~~~~~~~~~~~~~~
// MSB first out, received bits enter at bit 0, clk_idle must match the core's sclk idle level
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine #(
    parameter logic clk_idle = 1'b0
) (
    input  wire logic                          clock,
    spi_phase_if.engine                        phase,
    input  wire spi_pkg::spi_config_t          cfg,
    input  wire logic [spi_pkg::spi_data_w-1:0] tx_word,
    input  wire logic                          miso,
    output logic                               mosi,
    output logic [spi_pkg::spi_data_w-1:0]     rx_word
);

    import spi_pkg::*;

    logic [spi_data_w-1:0]   tx_reg;
    logic [spi_data_w-1:0]   rx_reg;
    logic [spi_bitcnt_w-1:0] bit_cnt;
    logic [spi_bitcnt_w-1:0] bit_cnt_next;

    // edge field equal to the idle level means the second half (clk_inv)
    logic in_on_first;
    logic out_on_first;
    logic capture_now;
    logic launch_now;

    assign bit_cnt_next = bit_cnt + 1'b1;
    assign phase.last_bit = (bit_cnt_next == spi_bitcnt_w'(cfg.num_bits));

    assign in_on_first  = (cfg.datain_edge != clk_idle);
    assign out_on_first = (cfg.dataout_edge != clk_idle);

    // sample miso once per bit at the chosen half
    assign capture_now = phase.half_done && (phase.first_half == in_on_first);

    // no shift before the first bit, bit 31 is already on mosi
    // and no shift after the last bit in the second half
    always_comb begin
        launch_now = 1'b0;
        if (phase.half_done) begin
            if (phase.first_half) begin
                launch_now = out_on_first && (bit_cnt != '0);
            end else begin
                launch_now = !out_on_first && !phase.last_bit;
            end
        end
    end

    // bit counter, one count per full sclk period
    always_ff @(posedge clock) begin
        if (phase.clear) begin
            bit_cnt <= '0;
        end else if (phase.half_done && !phase.first_half) begin
            bit_cnt <= bit_cnt_next;
        end
    end

    // transmit shifter
    always_ff @(posedge clock) begin
        if (phase.load) begin
            tx_reg <= tx_word;
        end else if (launch_now) begin
            tx_reg <= {tx_reg[spi_data_w-2:0], 1'b0};
        end
    end

    // receive shifter, older bits move up
    always_ff @(posedge clock) begin
        if (capture_now) begin
            rx_reg <= {rx_reg[spi_data_w-2:0], miso};
        end
    end

    assign mosi    = tx_reg[spi_data_w-1];
    assign rx_word = rx_reg;

endmodule

`default_nettype wire
